// ==== cpu_pkg.sv ====
package cpu_pkg;

    // widths
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IADDR_W    = 10;
    localparam int DADDR_W    = 10;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    // word addresses, not byte addresses
    typedef logic [IADDR_W-1:0]    iaddr_t;
    typedef logic [DADDR_W-1:0]    daddr_t;

    // major opcodes
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    // custom-0, sends rs1 to the output stream
    localparam logic [6:0] OP_OUT    = 7'b0001011;

    // alu funct3
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // output fifo
    localparam int OUT_DEPTH = 4;
    localparam int OUT_PTR_W = 2;

endpackage

// ==== regs.sv ====
`timescale 1ns/10ps

module regs (
    input  logic               clk,
    input  logic               rstn,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2
);
    import cpu_pkg::*;

    word_t rf [32];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            // x0 never written, so it stays zero after reset
            rf[waddr] <= wdata;
        end
    end

    // read ports are asynchronous
    assign rdata1 = rf[raddr1];
    assign rdata2 = rf[raddr2];

endmodule

// ==== fetch.sv ====
`timescale 1ns/10ps

module fetch (
    input  logic            clk,
    input  logic            rstn,
    input  logic            fetch_req,
    input  cpu_pkg::iaddr_t pc,
    output cpu_pkg::iaddr_t imem_addr,
    input  cpu_pkg::word_t  imem_data,
    output logic            fetched,
    output cpu_pkg::word_t  inst
);

    // request seen on the previous edge
    logic req_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_q     <= 1'b0;
            fetched   <= 1'b0;
            imem_addr <= '0;
        end else begin
            req_q   <= fetch_req;
            // memory samples the address one edge after it is driven
            fetched <= req_q;
            if (fetch_req) begin
                imem_addr <= pc;
            end
        end
    end

    // word is on imem_data while fetched is high
    always_ff @(posedge clk) begin
        if (fetched) begin
            inst <= imem_data;
        end
    end

endmodule

// ==== decode.sv ====
`timescale 1ns/10ps

module decode (
    input  cpu_pkg::word_t     inst,
    output cpu_pkg::reg_addr_t rs1,
    output cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::reg_addr_t rd,
    output logic [2:0]         funct3,
    output logic               alt,
    output logic               use_imm,
    output cpu_pkg::word_t     imm,
    output logic               is_alu,
    output logic               is_lui,
    output logic               is_load,
    output logic               is_store,
    output logic               is_branch,
    output logic               is_jal,
    output logic               is_jalr,
    output logic               is_out
);
    import cpu_pkg::*;

    logic [6:0] opcode;
    logic       is_shift;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // instruction class
    assign is_alu    = (opcode == OP_OP) || (opcode == OP_IMM);
    assign is_lui    = (opcode == OP_LUI);
    assign is_load   = (opcode == OP_LOAD);
    assign is_store  = (opcode == OP_STORE);
    assign is_branch = (opcode == OP_BRANCH);
    assign is_jal    = (opcode == OP_JAL);
    assign is_jalr   = (opcode == OP_JALR);
    assign is_out    = (opcode == OP_OUT);

    assign use_imm  = (opcode == OP_IMM);
    assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL);

    // bit 30 is part of the immediate for addi, slti and friends
    assign alt = inst[30] && ((opcode == OP_OP) || (use_imm && is_shift));

    // immediate formats, all sign extended except U
    always_comb begin
        case (opcode)
            OP_STORE: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            OP_BRANCH: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OP_JAL: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OP_LUI: begin
                imm = {inst[31:12], 12'b0};
            end
            default: begin
                // I format for op-imm, loads and jalr
                imm = {{20{inst[31]}}, inst[31:20]};
            end
        endcase
    end

endmodule

// ==== alu.sv ====
`timescale 1ns/10ps

module alu (
    input  logic [2:0]     funct3,
    input  logic           alt,
    input  logic           use_imm,
    input  cpu_pkg::word_t a,
    input  cpu_pkg::word_t b,
    input  cpu_pkg::word_t imm,
    output cpu_pkg::word_t result,
    output logic           taken
);
    import cpu_pkg::*;

    word_t      opb;
    logic [4:0] shamt;

    assign opb   = use_imm ? imm : b;
    assign shamt = opb[4:0];

    always_comb begin
        case (funct3)
            F3_ADD:  result = alt ? (a - opb) : (a + opb);
            F3_SLL:  result = a << shamt;
            F3_SLT:  result = word_t'($signed(a) < $signed(opb));
            F3_XOR:  result = a ^ opb;
            F3_SRL:  result = a >> shamt;
            F3_OR:   result = a | opb;
            F3_AND:  result = a & opb;
            // sltu is not supported
            default: result = a + opb;
        endcase
    end

    // branch compare always uses both registers
    always_comb begin
        case (funct3)
            F3_BEQ:  taken = (a == b);
            F3_BNE:  taken = (a != b);
            F3_BLT:  taken = ($signed(a) < $signed(b));
            F3_BGE:  taken = ($signed(a) >= $signed(b));
            default: taken = 1'b0;
        endcase
    end

endmodule

// ==== cpu.sv ====
`timescale 1ns/10ps

module cpu (
    input  logic            clk,
    input  logic            rstn,
    output cpu_pkg::iaddr_t imem_addr,
    input  cpu_pkg::word_t  imem_data,
    output cpu_pkg::daddr_t dmem_addr,
    output cpu_pkg::word_t  dmem_wdata,
    input  cpu_pkg::word_t  dmem_rdata,
    output logic            dmem_we,
    output logic            dmem_re,
    output logic            push_valid,
    output cpu_pkg::word_t  push_data,
    input  logic            push_ready
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        S_FETCH,
        S_FETCH_WAIT,
        S_DECODE,
        S_EXECUTE,
        S_MEM_WAIT,
        S_WRITE
    } state_t;

    state_t state;
    iaddr_t pc;
    iaddr_t pc_plus1;
    iaddr_t branch_target;
    iaddr_t exec_next_pc;
    iaddr_t next_pc;

    logic  fetch_req;
    logic  fetched;
    word_t inst;

    // decoder outputs
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    reg_addr_t  rd_d;
    logic [2:0] funct3_d;
    logic       alt_d;
    logic       use_imm_d;
    word_t      imm_d;
    logic       is_alu_d;
    logic       is_lui_d;
    logic       is_load_d;
    logic       is_store_d;
    logic       is_branch_d;
    logic       is_jal_d;
    logic       is_jalr_d;
    logic       is_out_d;
    word_t      rdata1;
    word_t      rdata2;

    // fields held from decode through write
    word_t      a_q;
    word_t      b_q;
    reg_addr_t  rd_q;
    logic [2:0] funct3_q;
    logic       alt_q;
    logic       use_imm_q;
    word_t      imm_q;
    logic       is_lui_q;
    logic       is_load_q;
    logic       is_store_q;
    logic       is_branch_q;
    logic       is_jal_q;
    logic       is_jalr_q;
    logic       is_out_q;
    logic       wb_en;
    word_t      wb_data;
    logic       rf_we;

    word_t alu_result;
    logic  taken;
    word_t eff_addr;
    word_t link;

    regs i_regs (
        .clk    (clk),
        .rstn   (rstn),
        .we     (rf_we),
        .waddr  (rd_q),
        .wdata  (wb_data),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    fetch i_fetch (
        .clk       (clk),
        .rstn      (rstn),
        .fetch_req (fetch_req),
        .pc        (pc),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .fetched   (fetched),
        .inst      (inst)
    );

    decode i_decode (
        .inst      (inst),
        .rs1       (rs1_addr),
        .rs2       (rs2_addr),
        .rd        (rd_d),
        .funct3    (funct3_d),
        .alt       (alt_d),
        .use_imm   (use_imm_d),
        .imm       (imm_d),
        .is_alu    (is_alu_d),
        .is_lui    (is_lui_d),
        .is_load   (is_load_d),
        .is_store  (is_store_d),
        .is_branch (is_branch_d),
        .is_jal    (is_jal_d),
        .is_jalr   (is_jalr_d),
        .is_out    (is_out_d)
    );

    alu i_alu (
        .funct3  (funct3_q),
        .alt     (alt_q),
        .use_imm (use_imm_q),
        .a       (a_q),
        .b       (b_q),
        .imm     (imm_q),
        .result  (alu_result),
        .taken   (taken)
    );

    assign pc_plus1      = pc + 1'b1;
    // byte offsets become word offsets
    assign branch_target = pc + imm_q[IADDR_W+1:2];
    assign eff_addr      = a_q + imm_q;
    assign link          = word_t'({pc_plus1, 2'b00});

    always_comb begin
        exec_next_pc = pc_plus1;
        if ((is_branch_q && taken) || is_jal_q) begin
            exec_next_pc = branch_target;
        end else if (is_jalr_q) begin
            exec_next_pc = eff_addr[IADDR_W+1:2];
        end
    end

    assign fetch_req  = (state == S_FETCH);
    assign dmem_re    = (state == S_EXECUTE) && is_load_q;
    assign dmem_we    = (state == S_EXECUTE) && is_store_q;
    assign dmem_addr  = eff_addr[DADDR_W+1:2];
    assign dmem_wdata = b_q;
    // held until the fifo takes it
    assign push_valid = (state == S_EXECUTE) && is_out_q;
    assign push_data  = a_q;
    assign rf_we      = (state == S_WRITE) && wb_en;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= S_FETCH;
            pc          <= '0;
            wb_en       <= 1'b0;
            is_lui_q    <= 1'b0;
            is_load_q   <= 1'b0;
            is_store_q  <= 1'b0;
            is_branch_q <= 1'b0;
            is_jal_q    <= 1'b0;
            is_jalr_q   <= 1'b0;
            is_out_q    <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    state <= S_FETCH_WAIT;
                end
                S_FETCH_WAIT: begin
                    if (fetched) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    is_lui_q    <= is_lui_d;
                    is_load_q   <= is_load_d;
                    is_store_q  <= is_store_d;
                    is_branch_q <= is_branch_d;
                    is_jal_q    <= is_jal_d;
                    is_jalr_q   <= is_jalr_d;
                    is_out_q    <= is_out_d;
                    wb_en <= is_alu_d || is_lui_d || is_load_d || is_jal_d || is_jalr_d;
                    state <= S_EXECUTE;
                end
                S_EXECUTE: begin
                    if (is_load_q || is_store_q) begin
                        state <= S_MEM_WAIT;
                    end else if (!is_out_q || push_ready) begin
                        // unknown opcodes fall through as a nop
                        state <= S_WRITE;
                    end
                end
                S_MEM_WAIT: begin
                    state <= S_WRITE;
                end
                S_WRITE: begin
                    pc    <= next_pc;
                    state <= S_FETCH;
                end
                default: begin
                    state <= S_FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            a_q       <= rdata1;
            b_q       <= rdata2;
            rd_q      <= rd_d;
            funct3_q  <= funct3_d;
            alt_q     <= alt_d;
            use_imm_q <= use_imm_d;
            imm_q     <= imm_d;
        end
        if (state == S_EXECUTE) begin
            next_pc <= exec_next_pc;
            if (is_lui_q) begin
                wb_data <= imm_q;
            end else if (is_jal_q || is_jalr_q) begin
                wb_data <= link;
            end else begin
                wb_data <= alu_result;
            end
        end
        // load data arrives the cycle after dmem_re
        if (state == S_MEM_WAIT) begin
            wb_data <= dmem_rdata;
        end
    end

endmodule

// ==== out_fifo.sv ====
`timescale 1ns/10ps

module out_fifo (
    input  logic           clk,
    input  logic           rstn,
    input  logic           push_valid,
    input  cpu_pkg::word_t push_data,
    output logic           push_ready,
    output logic           out_valid,
    output cpu_pkg::word_t out_data,
    input  logic           out_ready
);
    import cpu_pkg::*;

    word_t                mem [OUT_DEPTH];
    logic [OUT_PTR_W-1:0] wr_ptr;
    logic [OUT_PTR_W-1:0] rd_ptr;
    logic [OUT_PTR_W:0]   count;
    logic                 push;
    logic                 pop;

    assign push_ready = (count != (OUT_PTR_W + 1)'(OUT_DEPTH));
    assign out_valid  = (count != '0);
    // head entry stays put until popped
    assign out_data   = mem[rd_ptr];

    assign push = push_valid && push_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap, depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/10ps

module cpu_top (
    input  logic            clk,
    input  logic            rstn,
    output cpu_pkg::iaddr_t imem_addr,
    input  cpu_pkg::word_t  imem_data,
    output cpu_pkg::daddr_t dmem_addr,
    output cpu_pkg::word_t  dmem_wdata,
    input  cpu_pkg::word_t  dmem_rdata,
    output logic            dmem_we,
    output logic            dmem_re,
    output logic            out_valid,
    input  logic            out_ready,
    output cpu_pkg::word_t  out_data
);
    import cpu_pkg::*;

    // core to fifo
    logic  push_valid;
    logic  push_ready;
    word_t push_data;

    cpu i_cpu (
        .clk        (clk),
        .rstn       (rstn),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .push_valid (push_valid),
        .push_data  (push_data),
        .push_ready (push_ready)
    );

    out_fifo i_out_fifo (
        .clk        (clk),
        .rstn       (rstn),
        .push_valid (push_valid),
        .push_data  (push_data),
        .push_ready (push_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_ready  (out_ready)
    );

endmodule

// ==== tb_cpu_chk.sv ====
`timescale 1ns/10ps

module tb_cpu_chk (
    input logic            clk,
    input logic            rstn,
    input logic            out_valid,
    input logic            out_ready,
    input cpu_pkg::word_t  out_data,
    input logic            dmem_we,
    input logic            dmem_re,
    input cpu_pkg::iaddr_t imem_addr
);

    // fifo comes out of reset empty
    a_valid_after_reset: assert property (@(posedge clk) !rstn |=> !out_valid)
        else $error("out_valid is high in the cycle after reset");

    // a stalled word holds until the consumer takes it
    a_data_stable: assert property (@(posedge clk) disable iff (!rstn)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("out_data changed or was dropped while the stream was stalled");

    a_mem_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(dmem_we && dmem_re))
        else $error("dmem_we and dmem_re are high together");

    // requests come at least six cycles apart, so a new address holds through fetch_wait
    a_imem_addr_hold: assert property (@(posedge clk) disable iff (!rstn)
        $changed(imem_addr) |=> $stable(imem_addr))
        else $error("imem_addr changed without a new fetch request");

endmodule

// ==== tb_cpu.sv ====
`timescale 1ns/10ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int HALT_PC  = 63;
    localparam int TIMEOUT  = 20000;
    localparam int IDLE_CYC = 200;

    logic   clk = 1'b0;
    logic   rstn = 1'b0;
    logic   out_ready = 1'b0;
    word_t  imem_data = '0;
    word_t  dmem_rdata = '0;
    iaddr_t imem_addr;
    daddr_t dmem_addr;
    word_t  dmem_wdata;
    logic   dmem_we;
    logic   dmem_re;
    logic   out_valid;
    word_t  out_data;

    integer seed = 32'hcad0_413c;

    word_t prog [1024];
    word_t dmem [1024];
    // reference model state
    word_t m_mem [1024];
    word_t m_rf [32];
    word_t exp_q [$];

    int exp_cnt = 0;
    int rcv_cnt = 0;
    int n_checks = 0;
    int n_mismatch = 0;
    int n_other = 0;
    int edge_cnt = 0;

    cpu_top i_cpu_top (
        .clk        (clk),
        .rstn       (rstn),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data)
    );

    bind cpu_top tb_cpu_chk i_chk (
        .clk       (clk),
        .rstn      (rstn),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .dmem_we   (dmem_we),
        .dmem_re   (dmem_re),
        .imem_addr (imem_addr)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic word_t mem_fill(int addr);
        return (word_t'(addr) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    task automatic compare(input string name, input word_t want, input word_t got);
        n_checks++;
        if (want !== got) begin
            n_mismatch++;
            $display("** Error %s: expected %h, actual %h", name, want, got);
        end
    endtask

    // memories answer one cycle after the request
    always @(posedge clk) begin
        imem_data <= prog[imem_addr];
        if (!rstn) begin
            for (int i = 0; i < 1024; i++) begin
                dmem[i] <= mem_fill(i);
            end
        end else begin
            if (dmem_we) begin
                dmem[dmem_addr] <= dmem_wdata;
            end
            if (dmem_re) begin
                dmem_rdata <= dmem[dmem_addr];
            end
        end
    end

    // advance one clock edge and check any output word accepted at it
    task automatic clock_cycle();
        word_t want;
        @(posedge clk);
        if (rstn && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                n_other++;
                $display("extra output word %h beyond the %0d expected", out_data, exp_cnt);
            end else begin
                want = exp_q.pop_front();
                compare($sformatf("out[%0d]", rcv_cnt), want, out_data);
            end
            rcv_cnt++;
        end
        // stretches of rare ready fill the fifo and stall the core
        if (((edge_cnt / 256) % 2) == 0) begin
            out_ready <= ($random(seed) % 64) == 0;
        end else begin
            out_ready <= ($random(seed) % 4) != 0;
        end
        edge_cnt++;
    endtask

    // forward-only control flow, so every run reaches the halt
    task automatic gen_program();
        logic [31:0] r;
        logic [31:0] v;
        reg_addr_t   rd;
        reg_addr_t   ra;
        reg_addr_t   rb;
        reg_addr_t   src;
        logic [2:0]  f3;
        logic [2:0]  bf3;
        logic        alt;
        logic [11:0] imm12;
        logic [12:0] imm13;
        logic [20:0] imm21;
        int          off;
        for (int i = 0; i < 1024; i++) begin
            // unreachable filler is addi x0 carrying its own address
            prog[i] = {2'b00, 10'(i), 5'd0, F3_ADD, 5'd0, OP_IMM};
        end
        for (int pc = 0; pc < HALT_PC; pc++) begin
            r   = $random(seed);
            v   = $random(seed);
            rd  = {1'b0, r[7:4]};
            ra  = {1'b0, r[11:8]};
            rb  = {1'b0, r[15:12]};
            off = 1 + int'(r[17:16]);
            if (pc + off > HALT_PC) begin
                off = HALT_PC - pc;
            end
            alt = (r[25:23] == 3'd1);
            case (r[25:23])
                3'd0, 3'd1: f3 = F3_ADD;
                3'd2: f3 = F3_AND;
                3'd3: f3 = F3_OR;
                3'd4: f3 = F3_XOR;
                3'd5: f3 = F3_SLT;
                3'd6: f3 = F3_SLL;
                default: f3 = F3_SRL;
            endcase
            case (r[23:22])
                2'd0: bf3 = F3_BEQ;
                2'd1: bf3 = F3_BNE;
                2'd2: bf3 = F3_BLT;
                default: bf3 = F3_BGE;
            endcase
            imm12 = {6'b0, r[29:26], 2'b00};
            imm13 = 13'(off * 4);
            imm21 = 21'(off * 4);
            case (r[21:18])
                4'd0, 4'd1, 4'd2, 4'd3: begin
                    if (r[22] && !alt) begin
                        imm12 = (f3 == F3_SLL || f3 == F3_SRL) ? {7'b0, v[4:0]} : v[11:0];
                        prog[pc] = {imm12, ra, f3, rd, OP_IMM};
                    end else begin
                        prog[pc] = {1'b0, alt, 5'b0, rb, ra, f3, rd, OP_OP};
                    end
                end
                4'd4: prog[pc] = {v[19:0], rd, OP_LUI};
                // loads and stores stay in words 0..15 off x0
                4'd5: prog[pc] = {imm12, 5'd0, 3'b010, rd, OP_LOAD};
                4'd6: prog[pc] = {imm12[11:5], rb, 5'd0, 3'b010, imm12[4:0], OP_STORE};
                4'd7, 4'd8: begin
                    prog[pc] = {imm13[12], imm13[10:5], rb, ra, bf3, imm13[4:1], imm13[11],
                                OP_BRANCH};
                end
                4'd9: prog[pc] = {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd, OP_JAL};
                4'd10: prog[pc] = {12'((pc + off) * 4), 5'd0, 3'b000, rd, OP_JALR};
                default: begin
                    // x20..x23 are never written and must read as zero
                    src = r[22] ? (5'd20 + {3'b0, r[24:23]}) : ra;
                    prog[pc] = {12'b0, src, 3'b000, 5'b0, OP_OUT};
                end
            endcase
        end
        // jal x0 to itself
        prog[HALT_PC] = {20'b0, 5'd0, OP_JAL};
    endtask

    // instruction set interpreter over the same program
    task automatic run_model();
        word_t ins;
        word_t a;
        word_t b;
        word_t opb;
        word_t val;
        word_t ea;
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_j;
        int    pc;
        int    npc;
        int    steps;
        logic  wr;
        logic  tk;
        logic  halted;
        for (int i = 0; i < 1024; i++) begin
            m_mem[i] = mem_fill(i);
        end
        for (int i = 0; i < 32; i++) begin
            m_rf[i] = '0;
        end
        pc = 0;
        steps = 0;
        halted = 1'b0;
        while (!halted && steps < 5000) begin
            ins   = prog[pc];
            a     = m_rf[ins[19:15]];
            b     = m_rf[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            npc = pc + 1;
            wr  = 1'b0;
            val = '0;
            case (ins[6:0])
                OP_OP, OP_IMM: begin
                    opb = (ins[6:0] == OP_IMM) ? imm_i : b;
                    wr  = 1'b1;
                    case (ins[14:12])
                        F3_ADD: val = (ins[6:0] == OP_OP && ins[30]) ? a - opb : a + opb;
                        F3_SLL: val = a << opb[4:0];
                        F3_SLT: val = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
                        F3_XOR: val = a ^ opb;
                        F3_SRL: val = a >> opb[4:0];
                        F3_OR:  val = a | opb;
                        F3_AND: val = a & opb;
                        default: wr = 1'b0;
                    endcase
                end
                OP_LUI: begin
                    val = {ins[31:12], 12'b0};
                    wr  = 1'b1;
                end
                OP_LOAD: begin
                    ea  = a + imm_i;
                    val = m_mem[ea[11:2]];
                    wr  = 1'b1;
                end
                OP_STORE: begin
                    ea = a + imm_s;
                    m_mem[ea[11:2]] = b;
                end
                OP_BRANCH: begin
                    case (ins[14:12])
                        F3_BEQ: tk = (a == b);
                        F3_BNE: tk = (a != b);
                        F3_BLT: tk = ($signed(a) < $signed(b));
                        F3_BGE: tk = ($signed(a) >= $signed(b));
                        default: tk = 1'b0;
                    endcase
                    if (tk) begin
                        npc = pc + int'($signed(imm_b) >>> 2);
                    end
                end
                OP_JAL: begin
                    if (imm_j == '0) begin
                        halted = 1'b1;
                    end else begin
                        val = word_t'(4 * (pc + 1));
                        wr  = 1'b1;
                        npc = pc + int'($signed(imm_j) >>> 2);
                    end
                end
                OP_JALR: begin
                    ea  = a + imm_i;
                    val = word_t'(4 * (pc + 1));
                    wr  = 1'b1;
                    npc = int'(ea[11:2]);
                end
                OP_OUT: exp_q.push_back(a);
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                m_rf[ins[11:7]] = val;
            end
            if (!halted) begin
                pc = npc;
            end
            steps++;
        end
        if (!halted) begin
            n_other++;
            $display("reference model never reached the halt instruction");
        end
    endtask

    initial begin
        int cycles;
        gen_program();
        run_model();
        exp_cnt = exp_q.size();
        repeat (16) clock_cycle();
        rstn <= 1'b1;

        cycles = 0;
        while (rcv_cnt < exp_cnt && cycles < TIMEOUT) begin
            clock_cycle();
            cycles++;
        end
        if (rcv_cnt < exp_cnt) begin
            n_other++;
            $display("timeout: only %0d of %0d output words arrived", rcv_cnt, exp_cnt);
        end

        cycles = 0;
        while (imem_addr != iaddr_t'(HALT_PC) && cycles < TIMEOUT) begin
            clock_cycle();
            cycles++;
        end
        if (imem_addr != iaddr_t'(HALT_PC)) begin
            n_other++;
            $display("timeout: core never reached the halt loop");
        end

        // any word in the quiet window after the halt is an extra
        repeat (IDLE_CYC) clock_cycle();

        for (int i = 0; i < 32; i++) begin
            compare($sformatf("x%0d", i), m_rf[i], i_cpu_top.i_cpu.i_regs.rf[i]);
        end
        for (int i = 0; i < 16; i++) begin
            compare($sformatf("mem[%0d]", i), m_mem[i], dmem[i]);
        end
        compare("out count", word_t'(exp_cnt), word_t'(rcv_cnt));

        $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
cpu_pkg.sv
regs.sv
fetch.sv
decode.sv
alu.sv
cpu.sv
out_fifo.sv
cpu_top.sv
tb_cpu_chk.sv
tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --assert --timescale 1ns/10ps --top-module tb_cpu \
    -f compile.f -o tb_cpu_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_cpu_sim 2>&1 | tee sim.log

grep -q "^TEST RESULT: PASS$" sim.log && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
